// ==== verilog/snes_pad_pkg.sv ====
/*
 * Shared types for the pad router: console pad struct, decoded link port
 * struct, player slot array, device type codes and raw button indices
 */
`default_nettype none

package snes_pad_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Player slots, also the number of USB pads
	localparam int NUM_SLOTS = 5;

	// Raw button word width of one link port
	localparam int LLAPI_BUTTON_BITS = 32;

	// ======================================================================
	// Device type codes reported by a link port
	// ======================================================================

	// No device, or an Atari style pad that reports nothing
	localparam logic [7:0] DEV_TYPE_NONE = 8'd0;
	localparam logic [7:0] DEV_TYPE_INVALID = 8'd255;

	// Saturn pads, mapped with shoulder buttons instead of top face row
	localparam logic [7:0] DEV_SATURN_A = 8'd3;
	localparam logic [7:0] DEV_SATURN_B = 8'd8;

	// Raw button indices for the menu combination
	localparam int BTN_DOWN = 26;
	localparam int BTN_START = 5;
	localparam int BTN_FIRST = 0;

	// ======================================================================
	// Pad and port types
	// ======================================================================

	// Console pad layout, MSB first
	typedef struct packed {
		logic start;
		logic select;
		logic rt;
		logic lt;
		logic y;
		logic x;
		logic b;
		logic a;
		logic [3:0] dpad;
	} snes_pad_t;

	// One decoded link port word
	typedef struct packed {
		logic [LLAPI_BUTTON_BITS-1:0] buttons;
		logic [7:0] dev_type;
		logic link_en;
	} llapi_port_t;

	// Slot 0 sits in the low bits
	typedef snes_pad_t [NUM_SLOTS-1:0] pad_slots_t;

endpackage

`default_nettype wire

// ==== verilog/llapi_pad_mapper.sv ====
/*
 * One link port: presence detection with button latch,
 * Saturn or generic layout mapping and menu combination detect
 */
`timescale 1ns/1ps
`default_nettype none

module llapi_pad_mapper
	import snes_pad_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        link_select,
	input  logic        menu_open,
	input  llapi_port_t port,
	output snes_pad_t   pad,
	output logic        present,
	output logic        combo
);

	logic pressed;
	logic any_button;
	logic type_valid;
	logic is_saturn;
	logic link_active;
	logic present_next;
	logic combo_next;
	snes_pad_t pad_next;

	// ======================================================================
	// Presence
	// ======================================================================

	assign any_button = |port.buttons;

	// Types 0 and 255 mean nothing reliable is plugged in
	assign type_valid = (port.dev_type != DEV_TYPE_NONE) &&
		(port.dev_type != DEV_TYPE_INVALID);

	// Menu on screen suspends the link
	assign link_active = port.link_en && link_select && !menu_open;

	assign present_next = link_active && (type_valid || pressed || any_button);

	// Combo works even when the port is absent
	assign combo_next = port.buttons[BTN_DOWN] && port.buttons[BTN_START] &&
		port.buttons[BTN_FIRST];

	// ======================================================================
	// Layout mapping
	// ======================================================================

	assign is_saturn = (port.dev_type == DEV_SATURN_A) ||
		(port.dev_type == DEV_SATURN_B);

	always_comb begin
		// Generic layout
		pad_next.start = port.buttons[5];
		pad_next.select = port.buttons[4];
		pad_next.rt = port.buttons[7];
		pad_next.lt = port.buttons[6];
		pad_next.y = port.buttons[2];
		pad_next.x = port.buttons[3];
		pad_next.b = port.buttons[0];
		pad_next.a = port.buttons[1];
		pad_next.dpad = port.buttons[27:24];

		// Saturn has no select, Z takes its place; L and R as shoulders
		if (is_saturn) begin
			pad_next.select = port.buttons[6];
			pad_next.rt = port.buttons[9] | port.buttons[7];
			pad_next.lt = port.buttons[8];
		end
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
			present <= 1'b0;
			combo <= 1'b0;
		end else begin
			// Latch stays set until the next reset
			if (any_button)
				pressed <= 1'b1;
			present <= present_next;
			combo <= combo_next;
		end
	end

	always_ff @(posedge clk_sys) begin
		pad <= pad_next;
	end

endmodule

`default_nettype wire

// ==== verilog/player_slot_allocator.sv ====
/*
 * Player slot allocation: link pads take the first slots and the
 * USB pads move up to the next free ones; menu request merge
 */
`timescale 1ns/1ps
`default_nettype none

module player_slot_allocator
	import snes_pad_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  snes_pad_t  pad_a,
	input  snes_pad_t  pad_b,
	input  logic       present_a,
	input  logic       present_b,
	input  logic       combo_a,
	input  logic       combo_b,
	input  pad_slots_t usb_pads,
	output pad_slots_t slots,
	output logic       menu_request
);

	pad_slots_t usb_dly;
	pad_slots_t slots_next;
	logic [1:0] shift;

	// ======================================================================
	// USB alignment
	// ======================================================================

	// Matches the one cycle spent in the port mappers
	always_ff @(posedge clk_sys) begin
		usb_dly <= usb_pads;
	end

	// ======================================================================
	// Slot order
	// ======================================================================

	// Number of slots taken by link pads
	assign shift = {1'b0, present_a} + {1'b0, present_b};

	always_comb begin
		// Slot 0 is port A, or the first USB pad
		if (present_a)
			slots_next[0] = pad_a;
		else
			slots_next[0] = usb_dly[0];

		// Slot 1 is port B, else the next USB pad not yet used
		if (present_b)
			slots_next[1] = pad_b;
		else if (present_a)
			slots_next[1] = usb_dly[0];
		else
			slots_next[1] = usb_dly[1];

		// Remaining slots get USB pads pushed up by the link count
		for (int i = 2; i < NUM_SLOTS; i++) begin
			slots_next[i] = usb_dly[i - shift];
		end
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slots <= '0;
			menu_request <= 1'b0;
		end else begin
			slots <= slots_next;
			// Either port can bring up the menu
			menu_request <= combo_a | combo_b;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/snes_pad_router.sv ====
/*
 * Controller input top level: two link port mappers side by side
 * feeding the player slot allocator
 */
`timescale 1ns/1ps
`default_nettype none

module snes_pad_router
	import snes_pad_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        link_select,
	input  logic        menu_open,
	input  llapi_port_t port_a,
	input  llapi_port_t port_b,
	input  pad_slots_t  usb_pads,
	output pad_slots_t  slots,
	output logic        menu_request
);

	snes_pad_t pad_a;
	snes_pad_t pad_b;
	logic present_a;
	logic present_b;
	logic combo_a;
	logic combo_b;

	// ======================================================================
	// Link ports, one cycle each
	// ======================================================================

	llapi_pad_mapper mapper_a (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.link_select (link_select),
		.menu_open   (menu_open),
		.port        (port_a),
		.pad         (pad_a),
		.present     (present_a),
		.combo       (combo_a)
	);

	llapi_pad_mapper mapper_b (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.link_select (link_select),
		.menu_open   (menu_open),
		.port        (port_b),
		.pad         (pad_b),
		.present     (present_b),
		.combo       (combo_b)
	);

	// Second pipeline stage
	player_slot_allocator allocator (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pad_a        (pad_a),
		.pad_b        (pad_b),
		.present_a    (present_a),
		.present_b    (present_b),
		.combo_a      (combo_a),
		.combo_b      (combo_b),
		.usb_pads     (usb_pads),
		.slots        (slots),
		.menu_request (menu_request)
	);

endmodule

`default_nettype wire

// ==== bench/pad_model.svh ====
/*
 * Reference model for the pad router: layout mapping, presence,
 * menu combination and player slot order
 */
`ifndef PAD_MODEL_SVH
`define PAD_MODEL_SVH

// Console pad from one raw link word
function automatic snes_pad_t expected_pad(input llapi_port_t p);
	snes_pad_t m;
	logic saturn;
	saturn = (p.dev_type == DEV_SATURN_A) || (p.dev_type == DEV_SATURN_B);
	m.start = p.buttons[5];
	m.select = saturn ? p.buttons[6] : p.buttons[4];
	m.rt = saturn ? (p.buttons[9] | p.buttons[7]) : p.buttons[7];
	m.lt = saturn ? p.buttons[8] : p.buttons[6];
	m.y = p.buttons[2];
	m.x = p.buttons[3];
	m.b = p.buttons[0];
	m.a = p.buttons[1];
	m.dpad = p.buttons[27:24];
	return m;
endfunction

// Latch is the value held before this input set arrives
function automatic logic port_is_present(input llapi_port_t p, input logic lsel,
	input logic mopen, input logic latch);
	logic typed;
	typed = (p.dev_type != DEV_TYPE_NONE) && (p.dev_type != DEV_TYPE_INVALID);
	return p.link_en && lsel && !mopen && (typed || latch || (p.buttons != 32'd0));
endfunction

function automatic logic menu_combo(input llapi_port_t p);
	return p.buttons[BTN_DOWN] & p.buttons[BTN_START] & p.buttons[BTN_FIRST];
endfunction

// Link pads first, USB pads fill the rest in order
function automatic pad_slots_t order_slots(input snes_pad_t pa, input snes_pad_t pb,
	input logic pres_a, input logic pres_b, input pad_slots_t usb);
	pad_slots_t s;
	s = usb;
	if (pres_a && pres_b) begin
		s[0] = pa;
		s[1] = pb;
		s[2] = usb[0];
		s[3] = usb[1];
		s[4] = usb[2];
	end else if (pres_a) begin
		s[0] = pa;
		s[1] = usb[0];
		s[2] = usb[1];
		s[3] = usb[2];
		s[4] = usb[3];
	end else if (pres_b) begin
		s[0] = usb[0];
		s[1] = pb;
		s[2] = usb[1];
		s[3] = usb[2];
		s[4] = usb[3];
	end
	return s;
endfunction

`endif

// ==== bench/tb_snes_pad_router.sv ====
/*
 * Testbench for the pad router: xorshift stimulus, reference model
 * with its own pressed latches, two cycle delayed output checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_snes_pad_router
	import snes_pad_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TESTS = 6;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 300 + 3 * RESET_CYCLES;

	logic clk_sys;
	logic reset;
	logic link_select;
	logic menu_open;
	llapi_port_t port_a;
	llapi_port_t port_b;
	pad_slots_t usb_pads;
	pad_slots_t slots;
	logic menu_request;

	// Next input set, applied after the coming edge
	logic nx_reset;
	logic nx_link_select;
	logic nx_menu_open;
	llapi_port_t nx_port_a;
	llapi_port_t nx_port_b;
	pad_slots_t nx_usb;

	pad_slots_t exp_slots_d1;
	pad_slots_t exp_slots_d2;
	logic exp_menu_d1;
	logic exp_menu_d2;
	logic latch_a;
	logic latch_b;
	logic [31:0] rng_state;
	int fill;
	int errors;
	int checks;
	int failed_tests;
	int cycle_count;

	`include "pad_model.svh"

	snes_pad_router DUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.link_select  (link_select),
		.menu_open    (menu_open),
		.port_a       (port_a),
		.port_b       (port_b),
		.usb_pads     (usb_pads),
		.slots        (slots),
		.menu_request (menu_request)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Any type that is valid and not a Saturn pad
	function automatic logic [7:0] generic_type(input logic [31:0] r);
		if (r[7:0] == 8'd0 || r[7:0] == 8'd255 || r[7:0] == 8'd3 || r[7:0] == 8'd8)
			return 8'd1;
		return r[7:0];
	endfunction

	task automatic check_outputs();
		checks++;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (slots[i] !== exp_slots_d2[i]) begin
				$display("** Error at %0t: slots[%0d] expected %h got %h",
					$time, i, exp_slots_d2[i], slots[i]);
				errors++;
			end
		end
		if (menu_request !== exp_menu_d2) begin
			$display("** Error at %0t: menu_request expected %b got %b",
				$time, exp_menu_d2, menu_request);
			errors++;
		end
	endtask

	// Check the set from two edges back, then drive the next one
	task automatic advance();
		logic pres_a;
		logic pres_b;
		@(posedge clk_sys);
		#1;
		if (fill >= 2)
			check_outputs();
		exp_slots_d2 = exp_slots_d1;
		exp_menu_d2 = exp_menu_d1;
		reset = nx_reset;
		link_select = nx_link_select;
		menu_open = nx_menu_open;
		port_a = nx_port_a;
		port_b = nx_port_b;
		usb_pads = nx_usb;
		if (nx_reset) begin
			latch_a = 1'b0;
			latch_b = 1'b0;
			fill = 0;
		end else begin
			pres_a = port_is_present(nx_port_a, nx_link_select, nx_menu_open, latch_a);
			pres_b = port_is_present(nx_port_b, nx_link_select, nx_menu_open, latch_b);
			exp_slots_d1 = order_slots(expected_pad(nx_port_a), expected_pad(nx_port_b),
				pres_a, pres_b, nx_usb);
			exp_menu_d1 = menu_combo(nx_port_a) | menu_combo(nx_port_b);
			latch_a = latch_a | (nx_port_a.buttons != 32'd0);
			latch_b = latch_b | (nx_port_b.buttons != 32'd0);
			if (fill < 2)
				fill++;
		end
	endtask

	task automatic apply_reset();
		nx_reset = 1'b1;
		nx_link_select = 1'b0;
		nx_menu_open = 1'b0;
		nx_port_a = '0;
		nx_port_b = '0;
		nx_usb = '0;
		repeat (RESET_CYCLES) advance();
		if (slots !== '0 || menu_request !== 1'b0) begin
			$display("** Error at %0t: slots expected 0 got %h, menu_request expected 0 got %b",
				$time, slots, menu_request);
			errors++;
		end
		nx_reset = 1'b0;
	endtask

	task automatic stimulus(input int id, input int c);
		logic [31:0] r;
		logic [31:0] u;
		r = next_rand();
		nx_link_select = 1'b1;
		nx_menu_open = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			u = next_rand();
			nx_usb[i] = u[11:0];
		end
		nx_port_a.buttons = next_rand();
		nx_port_a.dev_type = generic_type(next_rand());
		nx_port_a.link_en = 1'b1;
		nx_port_b.buttons = next_rand();
		nx_port_b.dev_type = generic_type(next_rand());
		nx_port_b.link_en = 1'b1;
		case (id)
			1: begin
				nx_link_select = 1'b0;
				nx_port_a.link_en = r[0];
				nx_port_b.link_en = r[1];
			end
			3: begin
				if (c < 100)
					nx_port_b.link_en = 1'b0;
				else
					nx_port_a.link_en = 1'b0;
			end
			4: begin
				nx_port_a.dev_type = r[0] ? DEV_SATURN_A : DEV_SATURN_B;
				nx_port_b.dev_type = r[1] ? DEV_SATURN_A : DEV_SATURN_B;
			end
			5: begin
				// Buttons only at one cycle per port, latch keeps presence
				nx_port_a.dev_type = r[0] ? DEV_TYPE_NONE : DEV_TYPE_INVALID;
				nx_port_b.dev_type = r[1] ? DEV_TYPE_NONE : DEV_TYPE_INVALID;
				nx_port_a.buttons = (c == 20) ? (nx_port_a.buttons | 32'd1) : 32'd0;
				nx_port_b.buttons = (c == 30) ? (nx_port_b.buttons | 32'd1) : 32'd0;
				nx_menu_open = (c >= 40) && (c < 50);
			end
			6: begin
				nx_link_select = r[2];
				nx_menu_open = r[3];
				nx_port_a.link_en = r[4];
				nx_port_b.link_en = r[5];
				nx_port_a.dev_type = r[15:8];
				nx_port_b.dev_type = r[23:16];
				// Full combination forced, otherwise partial ones stay random
				if (r[6]) begin
					nx_port_a.buttons[BTN_DOWN] = 1'b1;
					nx_port_a.buttons[BTN_START] = 1'b1;
					nx_port_a.buttons[BTN_FIRST] = 1'b1;
				end
				if (r[7]) begin
					nx_port_b.buttons[BTN_DOWN] = 1'b1;
					nx_port_b.buttons[BTN_START] = 1'b1;
					nx_port_b.buttons[BTN_FIRST] = 1'b1;
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic run_test(input int id, input string name, input int n);
		int errs0;
		errs0 = errors;
		for (int c = 0; c < n; c++) begin
			// Fresh reset clears the latches before and after the latch sequence
			if (id == 5 && (c == 0 || c == 60))
				apply_reset();
			stimulus(id, c);
			advance();
		end
		advance();
		advance();
		if (errors == errs0) begin
			$display("test %0d %s: ok", id, name);
		end else begin
			$display("test %0d %s: %0d errors", id, name, errors - errs0);
			failed_tests++;
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		link_select = 1'b0;
		menu_open = 1'b0;
		port_a = '0;
		port_b = '0;
		usb_pads = '0;
		exp_slots_d1 = '0;
		exp_slots_d2 = '0;
		exp_menu_d1 = 1'b0;
		exp_menu_d2 = 1'b0;
		latch_a = 1'b0;
		latch_b = 1'b0;
		rng_state = 32'h4497eef4;
		fill = 0;
		errors = 0;
		checks = 0;
		failed_tests = 0;
		cycle_count = 0;
		apply_reset();
		run_test(1, "usb passthrough", 200);
		run_test(2, "both ports generic", 200);
		run_test(3, "single port shift", 200);
		run_test(4, "saturn layout", 200);
		run_test(5, "presence latch", 100);
		run_test(6, "menu combo", 200);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			NUM_TESTS, failed_tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
verilog/snes_pad_pkg.sv
verilog/llapi_pad_mapper.sv
verilog/player_slot_allocator.sv
verilog/snes_pad_router.sv
bench/tb_snes_pad_router.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the pad router testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f all.f \
	--top-module tb_snes_pad_router \
	-Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > "$LOG" 2>&1
cat "$LOG"

if grep -qx "TB PASSED" "$LOG"; then
	echo "simulation ok"
	exit 0
else
	echo "simulation reported failure"
	exit 1
fi
